// File: Makefile
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_core
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= === PASS ===

SOURCES := $(wildcard source/*.sv source/*.svh verification/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BUILD_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// File: sim.f
+incdir+source
source/rv_pkg.sv
source/decode_if.sv
source/rv_ifu.sv
source/rv_regfile.sv
source/rv_idu.sv
source/rv_exu.sv
source/rv_core.sv
verification/core_chk.sv
verification/tb_core.sv

// File: source/decode_if.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

interface decode_if;
  import rv_pkg::*;

  logic                valid;
  logic                ready;
  alu_op_e             alu_op;
  logic [`RV_XLEN-1:0] op1, op2, imm;
  logic [4:0]          rd;
  logic                rwen;
  logic                en_j;    // Jump or branch
  logic [`RV_XLEN-1:0] op_j;    // Base of jump target
  logic                ren, wen;
  logic [`RV_XLEN-1:0] rwaddr;
  logic [`RV_XLEN-1:0] sdata;
  logic [`RV_XLEN-1:0] pc;
  logic                illegal, halt;

  modport producer (output valid, alu_op, op1, op2, imm, rd, rwen, en_j, op_j,
                    ren, wen, rwaddr, sdata, pc, illegal, halt,
                    input ready);

  modport consumer (input valid, alu_op, op1, op2, imm, rd, rwen, en_j, op_j,
                    ren, wen, rwaddr, sdata, pc, illegal, halt,
                    output ready);
endinterface

// File: source/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data and address width
`define RV_XLEN 32

// First fetch address
`define RV_RESET_PC 32'h0000_0000

// Addresses wrap modulo this data memory depth in words
`define RV_DMEM_WORDS 64

`endif

// File: source/rv_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core (
  input  logic                clk,
  input  logic                rst,
  output logic [`RV_XLEN-1:0] imem_addr_o,
  input  logic [31:0]         imem_data_i,
  output logic                commit_valid_o,
  output logic [`RV_XLEN-1:0] commit_pc_o,
  output logic [4:0]          commit_rd_o,
  output logic [`RV_XLEN-1:0] commit_data_o,
  output logic                halt_o,
  output logic                illegal_o
);
  logic                fetch_valid, decode_ready;
  logic [31:0]         fetch_inst;
  logic [`RV_XLEN-1:0] fetch_pc;
  logic [4:0]          rs1, rs2;
  logic [`RV_XLEN-1:0] rdata1, rdata2;
  logic                rf_we;
  logic [4:0]          rf_waddr;
  logic [`RV_XLEN-1:0] rf_wdata;
  logic                redirect_valid;
  logic [`RV_XLEN-1:0] next_pc;

  decode_if dec_bus ();

  rv_ifu u_ifu (
    .clk, .rst,
    .redirect_valid_i(redirect_valid), .next_pc_i(next_pc),
    .decode_ready_i(decode_ready), .imem_data_i,
    .imem_addr_o, .fetch_valid_o(fetch_valid),
    .fetch_inst_o(fetch_inst), .fetch_pc_o(fetch_pc)
  );

  rv_idu u_idu (
    .clk, .rst,
    .prev_valid_i(fetch_valid), .inst_i(fetch_inst), .pc_i(fetch_pc),
    .ready_o(decode_ready), .rs1_o(rs1), .rs2_o(rs2),
    .reg_rdata1_i(rdata1), .reg_rdata2_i(rdata2), .dec(dec_bus.producer)
  );

  rv_exu u_exu (
    .clk, .rst, .dec(dec_bus.consumer),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .redirect_valid_o(redirect_valid), .next_pc_o(next_pc),
    .commit_valid_o, .commit_pc_o, .commit_rd_o, .commit_data_o,
    .halt_o, .illegal_o
  );

  rv_regfile u_regfile (
    .clk, .rst,
    .raddr1_i(rs1), .raddr2_i(rs2), .rdata1_o(rdata1), .rdata2_o(rdata2),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
  );
endmodule

// File: source/rv_exu.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_exu (
  input  logic                clk,
  input  logic                rst,
  decode_if.consumer          dec,
  output logic                rf_we_o,
  output logic [4:0]          rf_waddr_o,
  output logic [`RV_XLEN-1:0] rf_wdata_o,
  output logic                redirect_valid_o,
  output logic [`RV_XLEN-1:0] next_pc_o,
  output logic                commit_valid_o,
  output logic [`RV_XLEN-1:0] commit_pc_o,
  output logic [4:0]          commit_rd_o,
  output logic [`RV_XLEN-1:0] commit_data_o,
  output logic                halt_o,
  output logic                illegal_o
);
  import rv_pkg::*;

  localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

  exu_state_e          state;
  logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
  logic [`RV_XLEN-1:0] alu_res, npc, wb_data;
  logic [`RV_XLEN-1:0] res_q, npc_q, pc_q, addr_q, sdata_q;
  logic [4:0]          rd_q;
  logic                rwen_q, ren_q, wen_q, halt_q, illegal_q;
  logic                br_cond, taken;
  logic [DMEM_AW-1:0]  dm_idx;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:  alu_res = dec.op1 + dec.op2;
      ALU_SUB:  alu_res = dec.op1 - dec.op2;
      ALU_SLL:  alu_res = dec.op1 << dec.op2[4:0];
      ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(dec.op1) < $signed(dec.op2)};
      ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, dec.op1 < dec.op2};
      ALU_XOR:  alu_res = dec.op1 ^ dec.op2;
      ALU_SRL:  alu_res = dec.op1 >> dec.op2[4:0];
      ALU_SRA:  alu_res = $signed(dec.op1) >>> dec.op2[4:0];
      ALU_OR:   alu_res = dec.op1 | dec.op2;
      ALU_AND:  alu_res = dec.op1 & dec.op2;
      default:  alu_res = '0;
    endcase
  end

  // Branch funct3 compare
  always_comb begin
    case (dec.alu_op[2:0])
      3'b000:  br_cond = (dec.op1 == dec.op2);
      3'b001:  br_cond = (dec.op1 != dec.op2);
      3'b100:  br_cond = $signed(dec.op1) < $signed(dec.op2);
      3'b101:  br_cond = $signed(dec.op1) >= $signed(dec.op2);
      3'b110:  br_cond = dec.op1 < dec.op2;
      3'b111:  br_cond = dec.op1 >= dec.op2;
      default: br_cond = 1'b0;
    endcase
  end

  assign taken = dec.en_j && (dec.rwen || br_cond);  // Jumps link, branches do not
  assign npc   = taken ? ((dec.op_j + dec.imm) & ~`RV_XLEN'(1)) : dec.pc + `RV_XLEN'(4);
  assign dec.ready = (state == EXEC);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= EXEC;
      halt_o    <= 1'b0;
      illegal_o <= 1'b0;
    end else if (state == EXEC) begin
      if (dec.valid) state <= DONE;
    end else begin
      state <= EXEC;
      if (halt_q) halt_o <= 1'b1;
      if (illegal_q) illegal_o <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (state == EXEC && dec.valid) begin
      res_q     <= alu_res;
      npc_q     <= npc;
      pc_q      <= dec.pc;
      addr_q    <= dec.rwaddr;
      sdata_q   <= dec.sdata;
      rd_q      <= dec.rd;
      rwen_q    <= dec.rwen;
      ren_q     <= dec.ren;
      wen_q     <= dec.wen;
      halt_q    <= dec.halt;
      illegal_q <= dec.illegal;
    end
    if (state == DONE && wen_q) dmem[dm_idx] <= sdata_q;
  end

  assign dm_idx  = addr_q[DMEM_AW+1:2];
  assign wb_data = ren_q ? dmem[dm_idx] : res_q;  // LW reads in the commit cycle

  assign rf_we_o          = (state == DONE) && rwen_q;
  assign rf_waddr_o       = rd_q;
  assign rf_wdata_o       = wb_data;
  assign redirect_valid_o = (state == DONE) && !halt_q && !illegal_q;
  assign next_pc_o        = npc_q;
  assign commit_valid_o   = (state == DONE);
  assign commit_pc_o      = pc_q;
  assign commit_rd_o      = rwen_q ? rd_q : 5'd0;
  assign commit_data_o    = wb_data;
endmodule

// File: source/rv_idu.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_idu (
  input  logic                clk,
  input  logic                rst,
  input  logic                prev_valid_i,
  input  logic [31:0]         inst_i,
  input  logic [`RV_XLEN-1:0] pc_i,
  output logic                ready_o,
  output logic [4:0]          rs1_o,
  output logic [4:0]          rs2_o,
  input  logic [`RV_XLEN-1:0] reg_rdata1_i,
  input  logic [`RV_XLEN-1:0] reg_rdata2_i,
  decode_if.producer          dec
);
  import rv_pkg::*;

  stage_state_e        state;
  logic [31:0]         inst_q;
  logic [`RV_XLEN-1:0] pc_q;
  opcode_e             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = opcode_e'(inst_q[6:0]);
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];
  assign rs1_o  = inst_q[19:15];
  assign rs2_o  = inst_q[24:20];

  assign imm_i = {{(`RV_XLEN-12){inst_q[31]}}, inst_q[31:20]};
  assign imm_s = {{(`RV_XLEN-12){inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
  assign imm_b = {{(`RV_XLEN-13){inst_q[31]}}, inst_q[31], inst_q[7],
                  inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){inst_q[31]}}, inst_q[31], inst_q[19:12],
                  inst_q[20], inst_q[30:21], 1'b0};

  // Stage handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      dec.valid <= 1'b0;
      ready_o   <= 1'b1;
    end else begin
      case (state)
        IDLE: if (prev_valid_i) begin
          dec.valid <= 1'b1;
          ready_o   <= 1'b0;
          state     <= WAIT_READY;
        end
        WAIT_READY: if (dec.ready) begin
          dec.valid <= 1'b0;
          ready_o   <= 1'b1;
          state     <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (prev_valid_i && ready_o) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  assign dec.pc = pc_q;

  always_comb begin
    dec.alu_op  = ALU_ADD;
    dec.op1     = '0;
    dec.op2     = '0;
    dec.imm     = '0;
    dec.rd      = inst_q[11:7];
    dec.rwen    = 1'b0;
    dec.en_j    = 1'b0;
    dec.op_j    = pc_q;
    dec.ren     = 1'b0;
    dec.wen     = 1'b0;
    dec.rwaddr  = reg_rdata1_i + imm_i;
    dec.sdata   = reg_rdata2_i;
    dec.illegal = 1'b0;
    dec.halt    = 1'b0;
    case (opcode)
      OPC_LUI: begin
        dec.op2  = imm_u;
        dec.rwen = 1'b1;
      end
      OPC_AUIPC: begin
        dec.op1  = pc_q;
        dec.op2  = imm_u;
        dec.rwen = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin  // Link value is pc + 4
        dec.op1  = pc_q;
        dec.op2  = `RV_XLEN'(4);
        dec.imm  = (opcode == OPC_JAL) ? imm_j : imm_i;
        dec.op_j = (opcode == OPC_JAL) ? pc_q : reg_rdata1_i;
        dec.en_j = 1'b1;
        dec.rwen = 1'b1;
      end
      OPC_BRANCH: begin
        dec.alu_op = alu_op_e'({1'b0, funct3});  // Compare selector
        dec.op1    = reg_rdata1_i;
        dec.op2    = reg_rdata2_i;
        dec.imm    = imm_b;
        dec.en_j   = 1'b1;
      end
      OPC_OP_IMM: begin
        dec.alu_op = alu_op_e'({(funct3 == 3'b101) ? funct7[5] : 1'b0, funct3});
        dec.op1    = reg_rdata1_i;
        dec.op2    = imm_i;
        dec.rwen   = 1'b1;
      end
      OPC_OP: begin
        dec.alu_op = alu_op_e'({funct7[5], funct3});
        dec.op1    = reg_rdata1_i;
        dec.op2    = reg_rdata2_i;
        dec.rwen   = 1'b1;
      end
      OPC_LOAD: begin
        dec.illegal = (funct3 != 3'b010);  // Word only
        dec.ren     = (funct3 == 3'b010);
        dec.rwen    = (funct3 == 3'b010);
      end
      OPC_STORE: begin
        dec.rwaddr  = reg_rdata1_i + imm_s;
        dec.illegal = (funct3 != 3'b010);
        dec.wen     = (funct3 == 3'b010);
      end
      OPC_SYSTEM: begin
        dec.halt    = (inst_q == 32'h0000_0073);  // ECALL
        dec.illegal = (inst_q != 32'h0000_0073);
      end
      default: dec.illegal = 1'b1;
    endcase
  end
endmodule

// File: source/rv_ifu.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_ifu (
  input  logic                clk,
  input  logic                rst,
  input  logic                redirect_valid_i,
  input  logic [`RV_XLEN-1:0] next_pc_i,
  input  logic                decode_ready_i,
  input  logic [31:0]         imem_data_i,
  output logic [`RV_XLEN-1:0] imem_addr_o,
  output logic                fetch_valid_o,
  output logic [31:0]         fetch_inst_o,
  output logic [`RV_XLEN-1:0] fetch_pc_o
);
  import rv_pkg::*;

  stage_state_e        state;
  logic [`RV_XLEN-1:0] pc;
  logic                boot;  // First fetch after reset needs no redirect

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= IDLE;
      pc            <= `RV_RESET_PC;
      boot          <= 1'b1;
      fetch_valid_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (boot || redirect_valid_i) begin
            if (redirect_valid_i) pc <= next_pc_i;
            boot          <= 1'b0;
            fetch_valid_o <= 1'b1;
            state         <= WAIT_READY;
          end
        end
        WAIT_READY: begin
          if (decode_ready_i) begin  // Word taken by decode
            fetch_valid_o <= 1'b0;
            state         <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Memory answers in the same cycle
  assign imem_addr_o  = pc;
  assign fetch_inst_o = imem_data_i;
  assign fetch_pc_o   = pc;
endmodule

// File: source/rv_pkg.sv
package rv_pkg;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // Top bit is funct7[5] and low bits are funct3
  // Branches reuse the low bits as compare selector
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef enum logic {IDLE, WAIT_READY} stage_state_e;

  typedef enum logic {EXEC, DONE} exu_state_e;

endpackage

// File: source/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                rst,
  input  logic [4:0]          raddr1_i,
  input  logic [4:0]          raddr2_i,
  output logic [`RV_XLEN-1:0] rdata1_o,
  output logic [`RV_XLEN-1:0] rdata2_o,
  input  logic                we_i,
  input  logic [4:0]          waddr_i,
  input  logic [`RV_XLEN-1:0] wdata_i
);
  logic [`RV_XLEN-1:0] regs [1:31];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != 5'd0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];
endmodule

// File: verification/core_chk.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module core_chk (
  input logic                clk,
  input logic                rst,
  input logic                fetch_valid_i,
  input logic                decode_ready_i,
  input logic [`RV_XLEN-1:0] fetch_pc_i,
  input logic                commit_valid_i,
  input logic                halt_i
);
  int unsigned fail_count = 0;  // Read by the testbench at the end

  // Fetch holds its word until decode takes it
  valid_hold: assert property (@(posedge clk) disable iff (rst)
    fetch_valid_i && !decode_ready_i |=> fetch_valid_i && $stable(fetch_pc_i))
    else begin
      $error("fetch valid dropped or fetch PC moved before decode was ready");
      fail_count++;
    end

  commit_pulse: assert property (@(posedge clk) disable iff (rst)
    commit_valid_i |=> !commit_valid_i)
    else begin
      $error("commit_valid_o held for more than one cycle");
      fail_count++;
    end

  halt_sticky: assert property (@(posedge clk) disable iff (rst) halt_i |=> halt_i)
    else begin
      $error("halt_o cleared without reset");
      fail_count++;
    end

  no_commit_halted: assert property (@(posedge clk) disable iff (rst)
    halt_i |-> !commit_valid_i)
    else begin
      $error("commit seen while halted");
      fail_count++;
    end
endmodule

bind rv_core core_chk chk_i (
  .clk, .rst,
  .fetch_valid_i(fetch_valid), .decode_ready_i(decode_ready), .fetch_pc_i(fetch_pc),
  .commit_valid_i(commit_valid_o), .halt_i(halt_o)
);

// File: verification/tb_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_core;
  import rv_pkg::*;

  localparam int RESET_CYCLES  = 3;
  localparam int CYC_PER_INSTR = 10;  // Core needs three per instruction
  localparam int DRAIN_CYCLES  = 8;
  localparam int BR_F3  [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
  localparam int BR_RS1 [12] = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};  // Taken then not taken
  localparam int BR_RS2 [12] = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};

  logic                clk;
  logic                rst;
  logic [`RV_XLEN-1:0] imem_addr;
  logic [31:0]         imem_data;
  logic                commit_valid;
  logic [`RV_XLEN-1:0] commit_pc;
  logic [4:0]          commit_rd;
  logic [`RV_XLEN-1:0] commit_data;
  logic                halt, illegal;

  logic [31:0]         imem [256];
  logic [`RV_XLEN-1:0] mregs [32];              // Reference register file
  logic [`RV_XLEN-1:0] mdmem [`RV_DMEM_WORDS];  // Reference data memory that survives resets
  logic [`RV_XLEN-1:0] mpc;
  int                  prog_len;
  int                  cycle_count = 0;
  int                  cycle_limit = 20;
  int                  checks = 0;
  int                  errors = 0;

  rv_core dut_i (
    .clk, .rst,
    .imem_addr_o(imem_addr), .imem_data_i(imem_data),
    .commit_valid_o(commit_valid), .commit_pc_o(commit_pc), .commit_rd_o(commit_rd),
    .commit_data_o(commit_data), .halt_o(halt), .illegal_o(illegal)
  );

  assign imem_data = imem[imem_addr[9:2]];

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the core did not stop within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic logic [31:0] enc_r(logic [31:0] f7, rs2, rs1, f3, rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(logic [31:0] imm, rs1, f3, rd, opcode_e opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [31:0] imm, rs2, rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(logic [31:0] imm, rs2, rs1, f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(logic [31:0] imm20, rd, opcode_e opc);
    return {imm20[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_j(logic [31:0] imm, rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
  endfunction

  function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a, b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        else return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, logic [31:0] a, b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check_val(string what, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic clear_program();
    for (int i = 0; i < 256; i++) begin
      imem[i] = enc_i(i, 0, 1, 0, OPC_LOAD);  // LH x0 is rejected by the core
    end
    prog_len = 0;
  endtask

  task automatic emit(logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
    cycle_limit += CYC_PER_INSTR;
  endtask

  task automatic load_imm(int rd, logic [31:0] val);
    logic [31:0] upper;
    upper = (val + 32'h800) >> 12;  // ADDI sign extends the low part
    emit(enc_u(upper, rd, OPC_LUI));
    emit(enc_i(val, rd, 0, rd, OPC_OP_IMM));
  endtask

  // Executes the word at mpc by the ISA rules
  task automatic model_step(output logic [4:0] rd_e, output logic [31:0] data_e,
                            output logic stop_e, output logic ill_e);
    logic [31:0] w, a, b, imm_i, imm_s, imm_b, imm_j, npc;
    logic [2:0]  f3;
    int          ld_idx, st_idx;
    w      = imem[mpc[9:2]];
    f3     = w[14:12];
    a      = mregs[w[19:15]];
    b      = mregs[w[24:20]];
    imm_i  = {{20{w[31]}}, w[31:20]};
    imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    ld_idx = ((a + imm_i) >> 2) % `RV_DMEM_WORDS;
    st_idx = ((a + imm_s) >> 2) % `RV_DMEM_WORDS;
    npc    = mpc + 4;
    rd_e   = w[11:7];
    data_e = '0;
    stop_e = 1'b0;
    ill_e  = 1'b0;
    case (w[6:0])
      OPC_LUI:    data_e = {w[31:12], 12'b0};
      OPC_AUIPC:  data_e = mpc + {w[31:12], 12'b0};
      OPC_JAL: begin
        data_e = mpc + 4;
        npc    = mpc + imm_j;
      end
      OPC_JALR: begin
        data_e = mpc + 4;
        npc    = (a + imm_i) & ~32'd1;
      end
      OPC_BRANCH: begin
        rd_e = '0;
        if (branch_ref(f3, a, b)) npc = mpc + imm_b;
      end
      OPC_OP_IMM: data_e = alu_ref(f3, f3 == 3'd5 && w[30], a, imm_i);
      OPC_OP:     data_e = alu_ref(f3, w[30], a, b);
      OPC_LOAD: begin
        if (f3 == 3'b010) data_e = mdmem[ld_idx];
        else begin
          rd_e   = '0;
          stop_e = 1'b1;
          ill_e  = 1'b1;
        end
      end
      OPC_STORE: begin
        rd_e = '0;
        if (f3 == 3'b010) mdmem[st_idx] = b;
        else begin
          stop_e = 1'b1;
          ill_e  = 1'b1;
        end
      end
      OPC_SYSTEM: begin
        rd_e   = '0;
        stop_e = 1'b1;
        ill_e  = (w != 32'h0000_0073);  // Only ECALL is kept
      end
      default: begin
        rd_e   = '0;
        stop_e = 1'b1;
        ill_e  = 1'b1;
      end
    endcase
    if (rd_e != 5'd0) mregs[rd_e] = data_e;
    mpc = npc;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    mpc = `RV_RESET_PC;
    @(negedge clk);
    check_val("commit_valid_o after reset", commit_valid, 1'b0);
    check_val("halt_o after reset", halt, 1'b0);
    check_val("illegal_o after reset", illegal, 1'b0);
    check_val("first imem_addr_o", imem_addr, `RV_RESET_PC);
  endtask

  // Checks every commit against the model until the program stops
  task automatic run_program();
    logic [4:0]  rd_e;
    logic [31:0] data_e;
    logic        stop_e, ill_e;
    cycle_limit += RESET_CYCLES + DRAIN_CYCLES + 4;
    apply_reset();
    stop_e = 1'b0;
    ill_e  = 1'b0;
    while (!stop_e) begin
      @(negedge clk);
      if (commit_valid) begin
        check_val("commit_pc_o", commit_pc, mpc);
        model_step(rd_e, data_e, stop_e, ill_e);
        check_val("commit_rd_o", commit_rd, rd_e);
        if (rd_e != 5'd0) check_val("commit_data_o", commit_data, data_e);
      end
    end
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      check_val("commit_valid_o after stop", commit_valid, 1'b0);
    end
    check_val("halt_o", halt, !ill_e);
    check_val("illegal_o", illegal, ill_e);
  endtask

  task automatic test_reset_state();
    clear_program();
    emit(enc_i(0, 0, 0, 0, OPC_SYSTEM));
    run_program();
  endtask

  task automatic test_alu_ops();
    logic [31:0] imm;
    repeat (2) begin
      clear_program();
      load_imm(1, $urandom);
      load_imm(2, $urandom);
      for (int f3 = 0; f3 < 8; f3++) begin
        emit(enc_r(0, 2, 1, f3, 3 + f3));
      end
      emit(enc_r(32'h20, 2, 1, 0, 11));  // SUB
      emit(enc_r(32'h20, 2, 1, 5, 12));  // SRA
      for (int f3 = 0; f3 < 8; f3++) begin
        imm = $urandom;
        if (f3 == 1 || f3 == 5) imm = imm & 32'h1f;
        emit(enc_i(imm, 1, f3, 13 + f3, OPC_OP_IMM));
      end
      emit(enc_i(32'h400 | (imm & 32'h1f), 1, 5, 21, OPC_OP_IMM));  // SRAI
      emit(enc_i(5, 1, 0, 0, OPC_OP_IMM));  // Write to x0
      emit(enc_r(0, 2, 0, 0, 22));
      emit(enc_i(0, 0, 0, 0, OPC_SYSTEM));
      run_program();
    end
  endtask

  task automatic test_jumps();
    clear_program();
    emit(enc_u(32'h12345, 1, OPC_LUI));
    emit(enc_u(32'h00010, 2, OPC_AUIPC));
    emit(enc_j(12, 3));                     // 8 to 20
    emit(enc_i(1, 0, 0, 4, OPC_OP_IMM));
    emit(enc_i(2, 0, 0, 4, OPC_OP_IMM));
    emit(enc_i(36, 0, 0, 5, OPC_OP_IMM));
    emit(enc_i(5, 5, 0, 6, OPC_JALR));      // 24 to 40 with bit 0 cleared
    repeat (3) emit(enc_i(3, 0, 0, 4, OPC_OP_IMM));
    emit(enc_j(8, 7));                      // 40 to 48
    emit(enc_i(0, 0, 0, 0, OPC_SYSTEM));
    emit(enc_j(-4, 0));                     // Back to the ECALL
    run_program();
  endtask

  task automatic test_branches();
    clear_program();
    emit(enc_i(-5, 0, 0, 1, OPC_OP_IMM));
    emit(enc_i(3, 0, 0, 2, OPC_OP_IMM));
    emit(enc_i(3, 0, 0, 3, OPC_OP_IMM));
    for (int i = 0; i < 12; i++) begin
      emit(enc_b(8, BR_RS2[i], BR_RS1[i], BR_F3[i]));
      emit(enc_i(1, 10, 0, 10, OPC_OP_IMM));  // Runs only on fall-through
    end
    emit(enc_i(0, 0, 0, 0, OPC_SYSTEM));
    run_program();
  endtask

  task automatic test_memory();
    clear_program();
    load_imm(1, $urandom);
    load_imm(2, $urandom);
    emit(enc_i(64, 0, 0, 5, OPC_OP_IMM));
    emit(enc_s(0, 1, 5));
    emit(enc_s(8, 2, 5));
    emit(enc_i(0, 5, 2, 3, OPC_LOAD));
    emit(enc_i(8, 5, 2, 4, OPC_LOAD));
    emit(enc_s(0, 2, 5));                   // Overwrite the first word
    emit(enc_i(0, 5, 2, 6, OPC_LOAD));
    emit(enc_i(8, 5, 2, 7, OPC_LOAD));
    emit(enc_s(-4, 1, 5));
    emit(enc_i(-4, 5, 2, 8, OPC_LOAD));
    emit(enc_i(256, 5, 2, 9, OPC_LOAD));    // Wraps onto word 16
    emit(enc_i(0, 0, 0, 0, OPC_SYSTEM));
    run_program();
  endtask

  task automatic test_stop();
    clear_program();
    emit(enc_i(7, 0, 0, 1, OPC_OP_IMM));
    emit(enc_i(0, 0, 0, 0, OPC_SYSTEM));
    emit(enc_i(1, 0, 0, 2, OPC_OP_IMM));
    run_program();
    clear_program();
    emit(enc_i(8, 0, 0, 1, OPC_OP_IMM));
    emit(enc_i(0, 0, 1, 2, OPC_LOAD));      // LH
    emit(enc_i(1, 0, 0, 3, OPC_OP_IMM));
    run_program();
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    void'($urandom(32));
    test_reset_state();
    test_alu_ops();
    test_jumps();
    test_branches();
    test_memory();
    test_stop();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, dut_i.chk_i.fail_count);
    if (errors == 0 && dut_i.chk_i.fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end
endmodule
